/* common/spi_pkg.sv */
package spi_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int CMD_WIDTH  = 16;
	localparam int DATA_WIDTH = 8; // Shared by sdo, sdi and sync

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command fields
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int OP_MSB = 15;
	localparam int OP_LSB = 12;

	// Transfer length minus one, chip-select mask or sync id
	localparam int ARG_MSB = 7;
	localparam int ARG_LSB = 0;

	localparam int XFER_WR_BIT = 8;
	localparam int XFER_RD_BIT = 9;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [3:0] {
		OP_TRANSFER   = 4'h0,
		OP_CHIPSELECT = 4'h1,
		OP_SYNC       = 4'h3
	} spi_opcode_e;

endpackage

/* common/spi_stream_if.sv */
`timescale 1ns/1ps

interface spi_stream_if;
	import spi_pkg::*;

	logic                  cmd_valid;
	logic                  cmd_ready;
	logic [CMD_WIDTH-1:0]  cmd_data;

	logic                  sdo_valid;
	logic                  sdo_ready;
	logic [DATA_WIDTH-1:0] sdo_data;

	logic                  sdi_valid;
	logic                  sdi_ready;
	logic [DATA_WIDTH-1:0] sdi_data;

	logic                  sync_valid;
	logic                  sync_ready;
	logic [DATA_WIDTH-1:0] sync_data;

	// Command producer side
	modport source (
		output cmd_valid, cmd_data, sdo_valid, sdo_data, sdi_ready, sync_ready,
		input  cmd_ready, sdo_ready, sdi_valid, sdi_data, sync_valid, sync_data
	);

	// Command consumer side
	modport engine (
		input  cmd_valid, cmd_data, sdo_valid, sdo_data, sdi_ready, sync_ready,
		output cmd_ready, sdo_ready, sdi_valid, sdi_data, sync_valid, sync_data
	);

endinterface

/* src/spi_interconnect.sv */
`timescale 1ns/1ps

module spi_interconnect (
	input  logic         clk,
	input  logic         resetn,
	spi_stream_if.engine host,
	spi_stream_if.engine offload,
	spi_stream_if.source engine
);

	logic idle;
	logic grant_offload; // Low selects the host, high the offload
	logic sel_host;
	logic sel_offload;

	assign sel_host    = !idle && !grant_offload;
	assign sel_offload = !idle && grant_offload;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Source to engine
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign engine.cmd_valid = (sel_host && host.cmd_valid) || (sel_offload && offload.cmd_valid);
	assign engine.cmd_data  = grant_offload ? offload.cmd_data : host.cmd_data;
	assign host.cmd_ready    = sel_host && engine.cmd_ready;
	assign offload.cmd_ready = sel_offload && engine.cmd_ready;

	assign engine.sdo_valid = (sel_host && host.sdo_valid) || (sel_offload && offload.sdo_valid);
	assign engine.sdo_data  = grant_offload ? offload.sdo_data : host.sdo_data;
	assign host.sdo_ready    = sel_host && engine.sdo_ready;
	assign offload.sdo_ready = sel_offload && engine.sdo_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Engine to source
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign host.sdi_valid    = sel_host && engine.sdi_valid;
	assign offload.sdi_valid = sel_offload && engine.sdi_valid;
	assign host.sdi_data     = engine.sdi_data;
	assign offload.sdi_data  = engine.sdi_data;
	assign engine.sdi_ready = (sel_host && host.sdi_ready) || (sel_offload && offload.sdi_ready);

	assign host.sync_valid    = sel_host && engine.sync_valid;
	assign offload.sync_valid = sel_offload && engine.sync_valid;
	assign host.sync_data     = engine.sync_data;
	assign offload.sync_data  = engine.sync_data;
	assign engine.sync_ready =
		(sel_host && host.sync_ready) || (sel_offload && offload.sync_ready);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			idle          <= 1'b1;
			grant_offload <= 1'b0;
		end else begin
			// The host wins a tie
			if (idle) begin
				if (host.cmd_valid)
					grant_offload <= 1'b0;
				else if (offload.cmd_valid)
					grant_offload <= 1'b1;
			end

			// A grant holds until the program closes with its sync
			if (engine.sync_valid && engine.sync_ready)
				idle <= 1'b1;
			else if (host.cmd_valid || offload.cmd_valid)
				idle <= 1'b0;
		end
	end

endmodule

/* spi_execution/spi_execution.sv */
`timescale 1ns/1ps

module spi_execution #(
	parameter int CLK_DIV = 2,
	parameter int NUM_CS  = 2
) (
	input  logic              clk,
	input  logic              resetn,
	spi_stream_if.engine      ctrl,
	output logic              sclk,
	output logic              mosi,
	input  logic              miso,
	output logic [NUM_CS-1:0] cs_n
);
	import spi_pkg::*;

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int BIT_W = $clog2(DATA_WIDTH);

	typedef enum logic [2:0] {
		IDLE,
		CS_SET,
		WAIT_SDO,
		SHIFT,
		WAIT_SDI,
		SYNC
	} state_e;

	state_e                state;
	spi_opcode_e           opcode;
	logic [DATA_WIDTH-1:0] arg;
	logic                  cmd_fire;
	logic                  sdo_fire;
	logic                  sdi_fire;
	logic                  sync_fire;
	logic                  half_done;
	logic                  last_bit;
	logic                  byte_done;
	logic                  last_byte;

	logic [DIV_W-1:0]      div_cnt;
	logic [BIT_W-1:0]      bit_cnt;
	logic [DATA_WIDTH-1:0] byte_cnt; // Bytes still to go after the current one
	logic                  wr_en;
	logic                  rd_en;
	logic                  sclk_q;
	logic [DATA_WIDTH-1:0] tx_shift;
	logic [DATA_WIDTH-1:0] rx_shift;
	logic [DATA_WIDTH-1:0] sync_id;

	assign opcode    = spi_opcode_e'(ctrl.cmd_data[OP_MSB:OP_LSB]);
	assign arg       = ctrl.cmd_data[ARG_MSB:ARG_LSB];
	assign cmd_fire  = ctrl.cmd_valid && ctrl.cmd_ready;
	assign sdo_fire  = ctrl.sdo_valid && ctrl.sdo_ready;
	assign sdi_fire  = ctrl.sdi_valid && ctrl.sdi_ready;
	assign sync_fire = ctrl.sync_valid && ctrl.sync_ready;

	assign half_done = div_cnt == DIV_W'(CLK_DIV - 1); // Last cycle of an SCLK half period
	assign last_bit  = bit_cnt == BIT_W'(DATA_WIDTH - 1);
	assign last_byte = byte_cnt == '0;

	// A byte ends on its last falling edge, or once the read byte is taken
	assign byte_done = (state == SHIFT && half_done && sclk_q && last_bit && !rd_en) || sdi_fire;

	assign ctrl.cmd_ready  = state == IDLE;
	assign ctrl.sdo_ready  = state == WAIT_SDO;
	assign ctrl.sdi_valid  = state == WAIT_SDI;
	assign ctrl.sdi_data   = rx_shift;
	assign ctrl.sync_valid = state == SYNC;
	assign ctrl.sync_data  = sync_id;

	assign sclk = sclk_q;
	assign mosi = (state == SHIFT) && tx_shift[DATA_WIDTH-1];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state    <= IDLE;
			sclk_q   <= 1'b0;
			cs_n     <= '1;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			wr_en    <= 1'b0;
			rd_en    <= 1'b0;
		end else begin
			case (state)
				IDLE: if (cmd_fire) begin
					div_cnt <= '0;
					bit_cnt <= '0;
					case (opcode)
						OP_CHIPSELECT: begin
							cs_n  <= ~arg[NUM_CS-1:0];
							state <= CS_SET;
						end
						OP_TRANSFER: begin
							wr_en    <= ctrl.cmd_data[XFER_WR_BIT];
							rd_en    <= ctrl.cmd_data[XFER_RD_BIT];
							byte_cnt <= arg;
							state    <= ctrl.cmd_data[XFER_WR_BIT] ? WAIT_SDO : SHIFT;
						end
						OP_SYNC: state <= SYNC;
						default: state <= IDLE; // Unknown opcodes are dropped
					endcase
				end
				CS_SET: begin // Half a period of setup before the next command
					div_cnt <= div_cnt + 1'b1;
					if (half_done) begin
						div_cnt <= '0;
						state   <= IDLE;
					end
				end
				WAIT_SDO: if (sdo_fire) state <= SHIFT;
				SHIFT: begin
					div_cnt <= div_cnt + 1'b1;
					if (half_done) begin
						div_cnt <= '0;
						sclk_q  <= !sclk_q;
						if (sclk_q) begin // Falling edge closes a bit
							bit_cnt <= bit_cnt + 1'b1;
							if (last_bit && rd_en)
								state <= WAIT_SDI;
						end
					end
				end
				WAIT_SDI: begin
					// SCLK rests low here until the sdi byte is taken
				end
				SYNC: if (sync_fire) state <= IDLE;
				default: state <= IDLE;
			endcase

			if (byte_done) begin
				if (last_byte) begin
					state <= IDLE;
				end else begin
					byte_cnt <= byte_cnt - 1'b1;
					state    <= wr_en ? WAIT_SDO : SHIFT;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Shift data
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (cmd_fire && opcode == OP_TRANSFER)
			tx_shift <= '0; // Read-only transfers shift out zeros
		else if (sdo_fire)
			tx_shift <= ctrl.sdo_data;
		else if (state == SHIFT && half_done && sclk_q)
			tx_shift <= {tx_shift[DATA_WIDTH-2:0], 1'b0};

		if (state == SHIFT && half_done && !sclk_q)
			rx_shift <= {rx_shift[DATA_WIDTH-2:0], miso}; // Sample on the rising edge

		if (cmd_fire && opcode == OP_SYNC)
			sync_id <= arg;
	end

endmodule

/* spi_offload/spi_offload.sv */
`timescale 1ns/1ps

module spi_offload #(
	parameter int OFFLOAD_DEPTH = 16
) (
	input  logic                           clk,
	input  logic                           resetn,
	input  logic                           cmd_wr,
	input  logic [spi_pkg::CMD_WIDTH-1:0]  cmd_wdata,
	input  logic                           sdo_wr,
	input  logic [spi_pkg::DATA_WIDTH-1:0] sdo_wdata,
	input  logic                           clear,
	input  logic                           trigger,
	output logic                           sdi_valid,
	output logic [spi_pkg::DATA_WIDTH-1:0] sdi_data,
	output logic                           done,
	spi_stream_if.source                   link
);
	import spi_pkg::*;

	localparam int IDX_W = $clog2(OFFLOAD_DEPTH);
	localparam int PTR_W = IDX_W + 1;

	logic [CMD_WIDTH-1:0]  cmd_mem [OFFLOAD_DEPTH];
	logic [DATA_WIDTH-1:0] sdo_mem [OFFLOAD_DEPTH];

	logic [PTR_W-1:0] cmd_wr_ptr; // Also the program length
	logic [PTR_W-1:0] sdo_wr_ptr;
	logic [PTR_W-1:0] cmd_rd_ptr;
	logic [PTR_W-1:0] sdo_rd_ptr;
	logic             cmd_full;
	logic             sdo_full;
	logic             running;
	logic             start;

	assign cmd_full = cmd_wr_ptr == PTR_W'(OFFLOAD_DEPTH);
	assign sdo_full = sdo_wr_ptr == PTR_W'(OFFLOAD_DEPTH);
	assign start    = trigger && !running && cmd_wr_ptr != '0; // An empty program never starts

	always_ff @(posedge clk) begin
		if (cmd_wr && !cmd_full)
			cmd_mem[cmd_wr_ptr[IDX_W-1:0]] <= cmd_wdata;
		if (sdo_wr && !sdo_full)
			sdo_mem[sdo_wr_ptr[IDX_W-1:0]] <= sdo_wdata;
	end

	always_ff @(posedge clk) begin
		if (!resetn || clear) begin
			cmd_wr_ptr <= '0;
			sdo_wr_ptr <= '0;
			cmd_rd_ptr <= '0;
			sdo_rd_ptr <= '0;
			running    <= 1'b0;
			done       <= 1'b0;
		end else begin
			done <= 1'b0;
			if (cmd_wr && !cmd_full)
				cmd_wr_ptr <= cmd_wr_ptr + 1'b1;
			if (sdo_wr && !sdo_full)
				sdo_wr_ptr <= sdo_wr_ptr + 1'b1;

			if (start) begin
				running    <= 1'b1;
				cmd_rd_ptr <= '0;
				sdo_rd_ptr <= '0;
			end else if (running) begin
				if (link.cmd_valid && link.cmd_ready)
					cmd_rd_ptr <= cmd_rd_ptr + 1'b1;
				if (link.sdo_valid && link.sdo_ready)
					sdo_rd_ptr <= sdo_rd_ptr + 1'b1;
				if (link.sync_valid) begin // Sync is always accepted
					running <= 1'b0;
					done    <= 1'b1;
				end
			end
		end
	end

	assign link.cmd_valid  = running && cmd_rd_ptr != cmd_wr_ptr;
	assign link.cmd_data   = cmd_mem[cmd_rd_ptr[IDX_W-1:0]];
	assign link.sdo_valid  = running && sdo_rd_ptr != sdo_wr_ptr;
	assign link.sdo_data   = sdo_mem[sdo_rd_ptr[IDX_W-1:0]];
	assign link.sdi_ready  = 1'b1;
	assign link.sync_ready = 1'b1;

	assign sdi_valid = link.sdi_valid;
	assign sdi_data  = link.sdi_data;

endmodule

/* src/spi_subsystem_top.sv */
`timescale 1ns/1ps

module spi_subsystem_top #(
	parameter int CLK_DIV       = 2,
	parameter int NUM_CS        = 2,
	parameter int OFFLOAD_DEPTH = 16
) (
	input  logic                           clk,
	input  logic                           resetn,

	input  logic                           cmd_valid,
	output logic                           cmd_ready,
	input  logic [spi_pkg::CMD_WIDTH-1:0]  cmd_data,
	input  logic                           sdo_valid,
	output logic                           sdo_ready,
	input  logic [spi_pkg::DATA_WIDTH-1:0] sdo_data,
	output logic                           sdi_valid,
	input  logic                           sdi_ready,
	output logic [spi_pkg::DATA_WIDTH-1:0] sdi_data,
	output logic                           sync_valid,
	input  logic                           sync_ready,
	output logic [spi_pkg::DATA_WIDTH-1:0] sync_data,

	input  logic                           offload_cmd_wr,
	input  logic [spi_pkg::CMD_WIDTH-1:0]  offload_cmd_wdata,
	input  logic                           offload_sdo_wr,
	input  logic [spi_pkg::DATA_WIDTH-1:0] offload_sdo_wdata,
	input  logic                           offload_clear,
	input  logic                           offload_trigger,
	output logic                           offload_sdi_valid,
	output logic [spi_pkg::DATA_WIDTH-1:0] offload_sdi_data,
	output logic                           offload_done,

	output logic                           sclk,
	output logic                           mosi,
	input  logic                           miso,
	output logic [NUM_CS-1:0]              cs_n
);

	spi_stream_if host_link ();
	spi_stream_if offload_link ();
	spi_stream_if engine_link ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host stream ports
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign host_link.cmd_valid  = cmd_valid;
	assign cmd_ready            = host_link.cmd_ready;
	assign host_link.cmd_data   = cmd_data;
	assign host_link.sdo_valid  = sdo_valid;
	assign sdo_ready            = host_link.sdo_ready;
	assign host_link.sdo_data   = sdo_data;
	assign sdi_valid            = host_link.sdi_valid;
	assign host_link.sdi_ready  = sdi_ready;
	assign sdi_data             = host_link.sdi_data;
	assign sync_valid           = host_link.sync_valid;
	assign host_link.sync_ready = sync_ready;
	assign sync_data            = host_link.sync_data;

	spi_interconnect spi_interconnect_i (
		.clk     (clk),
		.resetn  (resetn),
		.host    (host_link),
		.offload (offload_link),
		.engine  (engine_link)
	);

	spi_execution #(
		.CLK_DIV (CLK_DIV),
		.NUM_CS  (NUM_CS)
	) spi_execution_i (
		.clk    (clk),
		.resetn (resetn),
		.ctrl   (engine_link),
		.sclk   (sclk),
		.mosi   (mosi),
		.miso   (miso),
		.cs_n   (cs_n)
	);

	spi_offload #(
		.OFFLOAD_DEPTH (OFFLOAD_DEPTH)
	) spi_offload_i (
		.clk       (clk),
		.resetn    (resetn),
		.cmd_wr    (offload_cmd_wr),
		.cmd_wdata (offload_cmd_wdata),
		.sdo_wr    (offload_sdo_wr),
		.sdo_wdata (offload_sdo_wdata),
		.clear     (offload_clear),
		.trigger   (offload_trigger),
		.sdi_valid (offload_sdi_valid),
		.sdi_data  (offload_sdi_data),
		.done      (offload_done),
		.link      (offload_link)
	);

endmodule

/* test/tb_spi_tasks.svh */
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

int error_count = 0;
int check_count = 0;

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("mismatch %s: got %0h, expected %0h at %0t", name, got, exp, $time);
	end
endtask

task automatic compare_bytes(input string name, input logic [7:0] got_q[$], input int r);
	check_value({name, "_count"}, got_q.size(), row_nsdi[r]);
	for (int i = 0; i < got_q.size() && i < row_nsdi[r]; i++)
		check_value(name, got_q[i], row_sdi[r][i]);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host stream drivers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic drive_cmds(input int r);
	for (int i = 0; i < row_ncmd[r]; i++) begin
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd_data  = row_cmd[r][i];
		do @(posedge clk); while (!cmd_ready);
	end
	@(negedge clk);
	cmd_valid = 1'b0;
endtask

task automatic drive_sdo(input int r);
	for (int i = 0; i < row_nsdo[r]; i++) begin
		@(negedge clk);
		sdo_valid = 1'b1;
		sdo_data  = row_sdo[r][i];
		do @(posedge clk); while (!sdo_ready);
	end
	@(negedge clk);
	sdo_valid = 1'b0;
endtask

task automatic collect_sdi(input int r);
	int gap;
	int wait_cnt;
	gap      = $urandom_range(0, row_gap[r]);
	wait_cnt = 0;
	@(negedge clk);
	sdi_ready = (gap == 0);
	// Bytes are taken until the host sync arrives
	while (!host_sync_seen) begin
		@(posedge clk);
		if (sdi_valid && sdi_ready) begin
			host_sdi_q.push_back(sdi_data);
			gap      = $urandom_range(0, row_gap[r]);
			wait_cnt = 0;
		end else if (sdi_valid) begin
			check_value("sclk", sclk, 0); // SCLK must rest while a byte waits
			wait_cnt++;
		end
		@(negedge clk);
		sdi_ready = (wait_cnt >= gap);
	end
	sdi_ready = 1'b0;
endtask

task automatic collect_sync(input int r);
	@(negedge clk);
	sync_ready = 1'b1;
	do @(posedge clk); while (!sync_valid);
	host_sync_time = $time;
	host_sync_seen = 1'b1;
	check_value("sync_data", sync_data, row_sync[r]);
	check_value("cs_n", cs_n, row_cs[r]);
	@(negedge clk);
	sync_ready = 1'b0;
endtask

`endif

/* test/tb_spi_subsystem.sv */
`timescale 1ns/1ps

module tb_spi_subsystem;
	import spi_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int CLK_DIV     = 2;
	localparam int NUM_CS      = 2;
	localparam int ROWS        = 9;
	localparam int SRC_HOST    = 0;
	localparam int SRC_OFFLOAD = 1;
	localparam int SRC_PAIR    = 2; // Host row raced against the offload row after it

	logic clk;
	logic resetn;
	logic cmd_valid, cmd_ready, sdo_valid, sdo_ready;
	logic sdi_valid, sdi_ready, sync_valid, sync_ready;
	logic [15:0] cmd_data;
	logic [7:0] sdo_data, sdi_data, sync_data;
	logic offload_cmd_wr, offload_sdo_wr, offload_clear, offload_trigger;
	logic [15:0] offload_cmd_wdata;
	logic [7:0] offload_sdo_wdata, offload_sdi_data;
	logic offload_sdi_valid, offload_done;
	logic sclk, mosi, miso;
	logic [NUM_CS-1:0] cs_n;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	int          row_src  [ROWS];
	int          row_gap  [ROWS]; // Longest sdi_ready low gap
	logic [15:0] row_cmd  [ROWS][4];
	int          row_ncmd [ROWS];
	logic [7:0]  row_sdo  [ROWS][8];
	int          row_nsdo [ROWS];
	logic [7:0]  row_sdi  [ROWS][8];
	int          row_nsdi [ROWS];
	logic [7:0]  row_sync [ROWS];
	logic [1:0]  row_cs   [ROWS];

	logic [7:0] host_sdi_q[$];
	logic [7:0] off_sdi_q[$];
	time        host_sync_time;
	bit         host_sync_seen;
	time        first_off_time;
	int         total_bytes = 0;
	int         wd_cycles = 0;

	`include "tb_spi_tasks.svh"

	assign miso = mosi; // Loopback

	spi_subsystem_top #(.CLK_DIV(CLK_DIV), .NUM_CS(NUM_CS)) spi_subsystem_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		if (offload_sdi_valid) begin
			off_sdi_q.push_back(offload_sdi_data);
			if (first_off_time == 0)
				first_off_time = $time;
		end
	end

	function automatic logic [15:0] encode_cmd(spi_opcode_e op, logic [7:0] arg, logic wr, logic rd);
		logic [15:0] c;
		c                  = '0;
		c[OP_MSB:OP_LSB]   = op;
		c[XFER_WR_BIT]     = wr;
		c[XFER_RD_BIT]     = rd;
		c[ARG_MSB:ARG_LSB] = arg;
		return c;
	endfunction

	task automatic start_row(input int r, input int src, input int gap);
		row_src[r]  = src;
		row_gap[r]  = gap;
		row_ncmd[r] = 0;
		row_nsdo[r] = 0;
		row_nsdi[r] = 0;
	endtask

	task automatic add_cs(input int r, input logic [1:0] mask);
		row_cmd[r][row_ncmd[r]] = encode_cmd(OP_CHIPSELECT, {6'b0, mask}, 1'b0, 1'b0);
		row_ncmd[r]++;
		row_cs[r] = ~mask;
	endtask

	task automatic add_sync(input int r, input logic [7:0] id);
		row_cmd[r][row_ncmd[r]] = encode_cmd(OP_SYNC, id, 1'b0, 1'b0);
		row_ncmd[r]++;
		row_sync[r] = id;
	endtask

	// Loopback returns the written byte, or zero when nothing is written
	task automatic add_transfer(input int r, input int len, input logic wr, input logic rd);
		logic [7:0] b;
		row_cmd[r][row_ncmd[r]] = encode_cmd(OP_TRANSFER, 8'(len - 1), wr, rd);
		row_ncmd[r]++;
		for (int i = 0; i < len; i++) begin
			b = wr ? 8'($urandom) : 8'h00;
			if (wr) begin
				row_sdo[r][row_nsdo[r]] = b;
				row_nsdo[r]++;
			end
			if (rd) begin
				row_sdi[r][row_nsdi[r]] = b;
				row_nsdi[r]++;
			end
		end
		total_bytes += len;
	endtask

	task automatic build_table();
		start_row(0, SRC_HOST, 0);
		add_cs(0, 2'b01);
		add_transfer(0, 1, 1, 1);
		add_sync(0, 8'ha1);
		start_row(1, SRC_HOST, 2);
		add_cs(1, 2'b10);
		add_transfer(1, 3, 1, 1);
		add_sync(1, 8'ha2);
		start_row(2, SRC_HOST, 0);
		add_transfer(2, 8, 1, 1);
		add_sync(2, 8'ha3);
		row_cs[2] = row_cs[1]; // No chip-select command, so the mask holds
		start_row(3, SRC_HOST, 1);
		add_cs(3, 2'b11);
		add_transfer(3, 2, 1, 0);
		add_transfer(3, 2, 0, 1);
		add_sync(3, 8'ha4);
		start_row(4, SRC_OFFLOAD, 0);
		add_cs(4, 2'b01);
		add_transfer(4, 4, 1, 1);
		add_sync(4, 8'h05);
		start_row(5, SRC_OFFLOAD, 0);
		add_cs(5, 2'b10);
		add_transfer(5, 4, 1, 1);
		add_sync(5, 8'h06);
		start_row(6, SRC_PAIR, 1);
		add_cs(6, 2'b01);
		add_transfer(6, 3, 1, 1);
		add_sync(6, 8'ha7);
		start_row(7, SRC_OFFLOAD, 0);
		add_cs(7, 2'b10);
		add_transfer(7, 4, 1, 1);
		add_sync(7, 8'h08);
		start_row(8, SRC_HOST, 6);
		add_cs(8, 2'b01);
		add_transfer(8, 5, 1, 1);
		add_sync(8, 8'ha9);
	endtask

	task automatic run_host_row(input int r);
		host_sdi_q.delete();
		host_sync_seen = 1'b0;
		fork
			drive_cmds(r);
			drive_sdo(r);
			collect_sdi(r);
			collect_sync(r);
		join
		compare_bytes("sdi_data", host_sdi_q, r);
	endtask

	task automatic load_offload(input int r);
		@(negedge clk);
		offload_clear = 1'b1;
		@(negedge clk);
		offload_clear = 1'b0;
		for (int i = 0; i < row_ncmd[r]; i++) begin
			offload_cmd_wr    = 1'b1;
			offload_cmd_wdata = row_cmd[r][i];
			@(negedge clk);
		end
		offload_cmd_wr = 1'b0;
		for (int i = 0; i < row_nsdo[r]; i++) begin
			offload_sdo_wr    = 1'b1;
			offload_sdo_wdata = row_sdo[r][i];
			@(negedge clk);
		end
		offload_sdo_wr = 1'b0;
		off_sdi_q.delete();
		first_off_time = 0;
	endtask

	task automatic trigger_offload(input int r);
		@(negedge clk);
		offload_trigger = 1'b1;
		@(negedge clk);
		offload_trigger = 1'b0;
		do @(posedge clk); while (!offload_done);
		compare_bytes("offload_sdi_data", off_sdi_q, r);
		check_value("cs_n", cs_n, row_cs[r]);
	endtask

	initial begin
		int r;
		void'($urandom(63));
		{cmd_valid, sdo_valid, sdi_ready, sync_ready} = '0;
		{offload_cmd_wr, offload_sdo_wr, offload_clear, offload_trigger} = '0;
		cmd_data          = '0;
		sdo_data          = '0;
		offload_cmd_wdata = '0;
		offload_sdo_wdata = '0;
		resetn            = 1'b0;
		build_table();
		wd_cycles = total_bytes * 16 * CLK_DIV * 2 + ROWS * 300 + 100;
		repeat (16) @(negedge clk);
		resetn = 1'b1;
		check_value("sclk", sclk, 0);
		check_value("mosi", mosi, 0);
		check_value("cs_n", cs_n, 2'b11);
		check_value("sdi_valid", sdi_valid, 0);
		check_value("sync_valid", sync_valid, 0);
		check_value("offload_done", offload_done, 0);

		r = 0;
		while (r < ROWS) begin
			if (row_src[r] == SRC_HOST) begin
				run_host_row(r);
				r = r + 1;
			end else if (row_src[r] == SRC_OFFLOAD) begin
				load_offload(r);
				trigger_offload(r);
				r = r + 1;
			end else begin
				load_offload(r + 1);
				fork
					trigger_offload(r + 1);
					begin
						@(negedge clk);
						run_host_row(r);
					end
				join
				check_value("host_before_offload", host_sync_time < first_off_time, 1);
				r = r + 2;
			end
		end

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		wait (wd_cycles > 0);
		#(wd_cycles * CLK_PERIOD);
		$display("error: watchdog expired after %0d clock cycles", wd_cycles);
		$display("checks %0d, errors %0d", check_count, error_count + 1);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+test
common/spi_pkg.sv
common/spi_stream_if.sv
src/spi_interconnect.sv
spi_execution/spi_execution.sv
spi_offload/spi_offload.sv
src/spi_subsystem_top.sv
test/tb_spi_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_spi_subsystem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
